// ==== project.f ====
hdl/fetch_pkg.sv
hdl/pc_ctrl.sv
hdl/fetch_cfg_regs.sv
hdl/fetch_mem_port.sv
hdl/inst_buffer.sv
hdl/fetch_top.sv
dv/fetch_mem_model.sv
dv/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_front_end

sources:
  # design, package first
  - files:
      - hdl/fetch_pkg.sv
      - hdl/pc_ctrl.sv
      - hdl/fetch_cfg_regs.sv
      - hdl/fetch_mem_port.sv
      - hdl/inst_buffer.sv
      - hdl/fetch_top.sv
  # verification
  - target: test
    files:
      - dv/fetch_mem_model.sv
      - dv/fetch_tb.sv

// ==== dv/fetch_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;

    localparam int unsigned CLK_PERIOD      = 40;
    localparam int unsigned RESET_CYCLES    = 8;
    localparam int unsigned IBUF_DEPTH      = 4;
    localparam int unsigned MEM_ADDR_W      = 19;
    localparam int unsigned STALL_CYCLES    = 48;   // inst_take held low this long
    localparam int unsigned QUIET_CYCLES    = 16;   // tail of a window that must see no reads
    localparam int unsigned WATCHDOG_CYCLES = 2000; // tests need roughly 500 cycles
    localparam fetch_pkg::fetch_word_t DATA_PATTERN = 64'h5a5a_0000_c3c3_0000;

    logic                   clock = 1'b0;
    logic                   reset_n;
    logic                   redirect_valid;
    fetch_pkg::pc_t         redirect_target;
    logic                   cfg_write;
    fetch_pkg::cfg_addr_t   cfg_addr;
    fetch_pkg::cfg_data_t   cfg_wdata;
    fetch_pkg::cfg_data_t   cfg_rdata;
    logic                   mem_rd_strobe;
    logic [MEM_ADDR_W-1:0]  mem_rd_addr;
    logic                   mem_rd_valid;
    fetch_pkg::fetch_word_t mem_rd_data;
    logic                   inst_valid;
    fetch_pkg::fetch_word_t inst_data;
    fetch_pkg::pc_t         inst_pc;
    logic                   inst_take;

    // monitor state, counters move with non-blocking updates
    int                     errors       = 0;
    int unsigned            strobe_count = 0;
    int unsigned            taken_count  = 0;
    logic                   rd_pending   = 1'b0;
    fetch_pkg::pc_t         exp_pc       = fetch_pkg::BOOT_ADDR_RESET;

    always #(CLK_PERIOD / 2) clock = ~clock;

    fetch_top #(
        .IBUF_DEPTH (IBUF_DEPTH),
        .MEM_ADDR_W (MEM_ADDR_W)
    ) fetch_top_i (
        .clock           (clock),
        .reset_n         (reset_n),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target),
        .cfg_write       (cfg_write),
        .cfg_addr        (cfg_addr),
        .cfg_wdata       (cfg_wdata),
        .cfg_rdata       (cfg_rdata),
        .mem_rd_strobe   (mem_rd_strobe),
        .mem_rd_addr     (mem_rd_addr),
        .mem_rd_valid    (mem_rd_valid),
        .mem_rd_data     (mem_rd_data),
        .inst_valid      (inst_valid),
        .inst_data       (inst_data),
        .inst_pc         (inst_pc),
        .inst_take       (inst_take)
    );

    fetch_mem_model #(
        .MEM_ADDR_W   (MEM_ADDR_W),
        .DATA_PATTERN (DATA_PATTERN)
    ) mem_i (
        .clock         (clock),
        .reset_n       (reset_n),
        .mem_rd_strobe (mem_rd_strobe),
        .mem_rd_addr   (mem_rd_addr),
        .mem_rd_valid  (mem_rd_valid),
        .mem_rd_data   (mem_rd_data)
    );

    // memory content rule, word index pc[21:3] mixed with the pattern
    function automatic fetch_pkg::fetch_word_t expected_word(input fetch_pkg::pc_t pc);
        return fetch_pkg::fetch_word_t'(pc[21:3]) ^ DATA_PATTERN;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] actual,
                                 input logic [63:0] expected);
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s = 0x%h, expected 0x%h",
                     $time, name, actual, expected);
        end
    endtask

    // every word the decoder takes is checked against the running pc
    always @(posedge clock) begin
        if (reset_n === 1'b1) begin
            if (mem_rd_strobe) begin
                strobe_count <= strobe_count + 1;
                rd_pending   <= 1'b1;
            end else if (mem_rd_valid) begin
                rd_pending <= 1'b0;
            end
            if (inst_valid && inst_take) begin
                compare_value("inst_pc", inst_pc, exp_pc);
                compare_value("inst_data", inst_data, expected_word(exp_pc));
                exp_pc      <= (exp_pc & ~64'h7) + 64'd8;   // next aligned word
                taken_count <= taken_count + 1;
            end
        end
    end

    task automatic wait_words(input int unsigned n);
        int unsigned goal;
        goal = taken_count + n;
        while (taken_count < goal) @(posedge clock);
    endtask

    task automatic write_reg(input fetch_pkg::cfg_addr_t addr, input fetch_pkg::cfg_data_t data);
        @(posedge clock);
        cfg_write <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clock);
        cfg_write <= 1'b0;
    endtask

    task automatic read_reg(input fetch_pkg::cfg_addr_t addr, output fetch_pkg::cfg_data_t data);
        @(posedge clock);
        cfg_addr <= addr;
        @(posedge clock);
        data = cfg_rdata;   // combinational, settled a full cycle
    endtask

    task automatic reset_test();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clock);
            if (i > 0) begin   // first edge clears the registers
                compare_value("inst_valid", inst_valid, 1'b0);
                compare_value("mem_rd_strobe", mem_rd_strobe, 1'b0);
            end
        end
        reset_n <= 1'b1;
        @(posedge clock);
        while (!mem_rd_strobe) @(posedge clock);
        compare_value("mem_rd_addr", mem_rd_addr, fetch_pkg::BOOT_ADDR_RESET[21:3]);
    endtask

    task automatic sequential_test();
        @(posedge clock);
        inst_take <= 1'b1;
        wait_words(12);
    endtask

    task automatic backpressure_test();
        int unsigned first;
        int unsigned mid;
        int unsigned last;
        @(posedge clock);
        inst_take <= 1'b0;
        @(posedge clock);
        first = strobe_count;   // reads from here on happen under stall
        repeat (STALL_CYCLES - QUIET_CYCLES) @(posedge clock);
        mid = strobe_count;
        repeat (QUIET_CYCLES) @(posedge clock);
        last = strobe_count;
        assert (last - first <= IBUF_DEPTH) else begin
            errors++;
            $display("%0d reads issued while the buffer was stalled, at most %0d allowed",
                     last - first, IBUF_DEPTH);
        end
        assert (last == mid) else begin
            errors++;
            $display("reads kept coming late in the stall window");
        end
        compare_value("inst_valid", inst_valid, 1'b1);
        inst_take <= 1'b1;
        wait_words(10);
    endtask

    task automatic redirect_test();
        fetch_pkg::pc_t target;
        target = 64'h0000_0000_0004_2014;   // not word aligned on purpose
        @(posedge clock);
        while (!mem_rd_strobe) @(posedge clock);
        redirect_valid  <= 1'b1;   // read just issued, still in flight
        redirect_target <= target;
        inst_take       <= 1'b0;
        @(posedge clock);
        redirect_valid <= 1'b0;
        inst_take      <= 1'b1;
        exp_pc         <= target;
        @(posedge clock);
        while (!mem_rd_strobe) @(posedge clock);
        compare_value("mem_rd_addr", mem_rd_addr, target[21:3]);
        wait_words(6);
    endtask

    task automatic config_test();
        fetch_pkg::pc_t       new_boot;
        fetch_pkg::cfg_data_t rdata;
        int unsigned          start;
        int unsigned          quiet_from;
        new_boot = 64'h0000_0000_0013_5a40;
        write_reg(fetch_pkg::CFG_BOOT_LO, new_boot[31:0]);
        write_reg(fetch_pkg::CFG_BOOT_HI, new_boot[63:32]);
        read_reg(fetch_pkg::CFG_BOOT_LO, rdata);
        compare_value("cfg_rdata BOOT_LO", rdata, new_boot[31:0]);
        // restart with enable kept on
        @(posedge clock);
        inst_take <= 1'b0;
        cfg_write <= 1'b1;
        cfg_addr  <= fetch_pkg::CFG_CTRL;
        cfg_wdata <= 32'h3;
        @(posedge clock);
        cfg_write <= 1'b0;
        inst_take <= 1'b1;
        exp_pc    <= new_boot;
        start = taken_count;
        read_reg(fetch_pkg::CFG_CTRL, rdata);
        compare_value("cfg_rdata CTRL", rdata, 32'h1);   // restart bit reads 0
        wait_words(6);
        write_reg(fetch_pkg::CFG_CTRL, 32'h0);
        repeat (4) @(posedge clock);   // a request already granted may still strobe
        while (rd_pending) @(posedge clock);
        quiet_from = strobe_count;
        repeat (QUIET_CYCLES) @(posedge clock);
        compare_value("strobes after disable", strobe_count - quiet_from, 0);
        compare_value("inst_valid", inst_valid, 1'b0);   // buffer drained
        read_reg(fetch_pkg::CFG_COUNT, rdata);
        compare_value("cfg_rdata COUNT", rdata, taken_count - start);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, tests did not finish, errors: %0d",
                 WATCHDOG_CYCLES, errors);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        reset_n         = 1'b0;
        redirect_valid  = 1'b0;
        redirect_target = '0;
        cfg_write       = 1'b0;
        cfg_addr        = '0;
        cfg_wdata       = '0;
        inst_take       = 1'b0;
        reset_test();
        sequential_test();
        backpressure_test();
        redirect_test();
        config_test();
        repeat (2) @(posedge clock);
        $display("errors: %0d, words checked: %0d, reads issued: %0d",
                 errors, taken_count, strobe_count);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/fetch_mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

// external memory stand-in, one read at a time, 1 to 4 cycles of latency
module fetch_mem_model #(
    parameter int unsigned           MEM_ADDR_W   = 19,
    parameter fetch_pkg::fetch_word_t DATA_PATTERN = 64'h5a5a_0000_c3c3_0000,
    parameter int unsigned           MAX_LATENCY  = 4
) (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   mem_rd_strobe,
    input  logic [MEM_ADDR_W-1:0]  mem_rd_addr,
    output logic                   mem_rd_valid,
    output fetch_pkg::fetch_word_t mem_rd_data
);

    integer                seed = 58393;   // fixed seed, same run every time
    logic                  pending;        // strobe seen, reply not yet sent
    logic [MEM_ADDR_W-1:0] addr_q;
    int unsigned           wait_left;      // extra cycles before the reply
    int unsigned           latency;        // drawn per read, 0 means reply next cycle

    // known values before the first clock edge
    initial begin
        mem_rd_valid = 1'b0;
        mem_rd_data  = '0;
        pending      = 1'b0;
        wait_left    = 0;
        latency      = 0;
    end

    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pending      <= 1'b0;
            wait_left    <= 0;
            mem_rd_valid <= 1'b0;
            mem_rd_data  <= '0;
        end else begin
            mem_rd_valid <= 1'b0;   // reply is a single pulse
            if (mem_rd_strobe) begin
                latency = $unsigned($random(seed)) % MAX_LATENCY;
                if (latency == 0) begin
                    mem_rd_valid <= 1'b1;   // shortest case, one cycle after the strobe
                    mem_rd_data  <= fetch_pkg::fetch_word_t'(mem_rd_addr) ^ DATA_PATTERN;
                end else begin
                    pending   <= 1'b1;
                    addr_q    <= mem_rd_addr;
                    wait_left <= latency - 1;
                end
            end else if (pending) begin
                if (wait_left == 0) begin
                    pending      <= 1'b0;
                    mem_rd_valid <= 1'b1;
                    // content is the word index mixed with a pattern
                    mem_rd_data  <= fetch_pkg::fetch_word_t'(addr_q) ^ DATA_PATTERN;
                end else begin
                    wait_left <= wait_left - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_top #(
    parameter int unsigned IBUF_DEPTH = 4,
    parameter int unsigned MEM_ADDR_W = fetch_pkg::MEM_ADDR_W
) (
    input  logic                   clock,
    input  logic                   reset_n,

    // branch unit
    input  logic                   redirect_valid,
    input  fetch_pkg::pc_t         redirect_target,

    // config bus
    input  logic                   cfg_write,
    input  fetch_pkg::cfg_addr_t   cfg_addr,
    input  fetch_pkg::cfg_data_t   cfg_wdata,
    output fetch_pkg::cfg_data_t   cfg_rdata,

    // external memory
    output logic                   mem_rd_strobe,
    output logic [MEM_ADDR_W-1:0]  mem_rd_addr,
    input  logic                   mem_rd_valid,
    input  fetch_pkg::fetch_word_t mem_rd_data,

    // decoder
    output logic                   inst_valid,
    output fetch_pkg::fetch_word_t inst_data,
    output fetch_pkg::pc_t         inst_pc,
    input  logic                   inst_take
);

    fetch_pkg::pc_t         boot_addr;
    logic                   fetch_enable;
    logic                   pc_redirect_valid;
    fetch_pkg::pc_t         pc_redirect_target;
    logic                   pc_index_valid;
    fetch_pkg::pc_t         pc_index;
    logic                   pc_index_ready;
    logic                   pc_operation_done;
    logic                   push_valid;
    fetch_pkg::fetch_word_t push_data;
    fetch_pkg::pc_t         push_pc;
    logic                   fetch_inst;

    fetch_cfg_regs cfg_regs_i (
        .clock              (clock),
        .reset_n            (reset_n),
        .cfg_write          (cfg_write),
        .cfg_addr           (cfg_addr),
        .cfg_wdata          (cfg_wdata),
        .cfg_rdata          (cfg_rdata),
        .redirect_valid     (redirect_valid),
        .redirect_target    (redirect_target),
        .pc_operation_done  (pc_operation_done),
        .boot_addr          (boot_addr),
        .fetch_enable       (fetch_enable),
        .pc_redirect_valid  (pc_redirect_valid),
        .pc_redirect_target (pc_redirect_target)
    );

    pc_ctrl pc_ctrl_i (
        .clock              (clock),
        .reset_n            (reset_n),
        .boot_addr          (boot_addr),
        .fetch_enable       (fetch_enable),
        .pc_redirect_valid  (pc_redirect_valid),
        .pc_redirect_target (pc_redirect_target),
        .fetch_inst         (fetch_inst),
        .pc                 (),                 // same value as pc_index
        .pc_index_valid     (pc_index_valid),
        .pc_index           (pc_index),
        .pc_index_ready     (pc_index_ready),
        .pc_operation_done  (pc_operation_done)
    );

    fetch_mem_port #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) mem_port_i (
        .clock             (clock),
        .reset_n           (reset_n),
        .pc_index_valid    (pc_index_valid),
        .pc_index          (pc_index),
        .pc_index_ready    (pc_index_ready),
        .pc_operation_done (pc_operation_done),
        .pc_redirect_valid (pc_redirect_valid),
        .mem_rd_strobe     (mem_rd_strobe),
        .mem_rd_addr       (mem_rd_addr),
        .mem_rd_valid      (mem_rd_valid),
        .mem_rd_data       (mem_rd_data),
        .push_valid        (push_valid),
        .push_data         (push_data),
        .push_pc           (push_pc)
    );

    inst_buffer #(
        .IBUF_DEPTH (IBUF_DEPTH)
    ) inst_buffer_i (
        .clock             (clock),
        .reset_n           (reset_n),
        .pc_redirect_valid (pc_redirect_valid),
        .push_valid        (push_valid),
        .push_data         (push_data),
        .push_pc           (push_pc),
        .fetch_inst        (fetch_inst),
        .inst_valid        (inst_valid),
        .inst_data         (inst_data),
        .inst_pc           (inst_pc),
        .inst_take         (inst_take)
    );

endmodule

`default_nettype wire

// ==== hdl/inst_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_buffer #(
    parameter int unsigned IBUF_DEPTH = 4
) (
    input  logic                   clock,
    input  logic                   reset_n,

    input  logic                   pc_redirect_valid,   // flush

    // from the memory port
    input  logic                   push_valid,
    input  fetch_pkg::fetch_word_t push_data,
    input  fetch_pkg::pc_t         push_pc,

    output logic                   fetch_inst,          // room for one more request

    // decoder side
    output logic                   inst_valid,
    output fetch_pkg::fetch_word_t inst_data,
    output fetch_pkg::pc_t         inst_pc,
    input  logic                   inst_take
);

    localparam int unsigned PTR_W = $clog2(IBUF_DEPTH);
    localparam int unsigned CNT_W = $clog2(IBUF_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    localparam ptr_t LAST_SLOT  = ptr_t'(IBUF_DEPTH - 1);
    localparam cnt_t FULL_COUNT = cnt_t'(IBUF_DEPTH);
    localparam cnt_t SPACE_MARK = cnt_t'(IBUF_DEPTH - 2);   // keeps a slot for the read in flight

    fetch_pkg::fetch_word_t data_mem [IBUF_DEPTH];
    fetch_pkg::pc_t         pc_mem   [IBUF_DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    logic push_ok;
    logic pop_ok;

    assign push_ok = push_valid & (count != FULL_COUNT) & ~pc_redirect_valid;
    assign pop_ok  = inst_take & inst_valid;   // take ignored while empty

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (pc_redirect_valid) begin
            wr_ptr <= '0;   // flush
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    // storage
    always_ff @(posedge clock) begin
        if (push_ok) begin
            data_mem[wr_ptr] <= push_data;
            pc_mem[wr_ptr]   <= push_pc;
        end
    end

    assign inst_valid = (count != '0);   // one cycle after the push
    assign inst_data  = data_mem[rd_ptr];
    assign inst_pc    = pc_mem[rd_ptr];

    assign fetch_inst = (count <= SPACE_MARK);

endmodule

`default_nettype wire

// ==== hdl/fetch_mem_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_mem_port #(
    parameter int unsigned MEM_ADDR_W = fetch_pkg::MEM_ADDR_W
) (
    input  logic                   clock,
    input  logic                   reset_n,

    // index handshake from pc_ctrl
    input  logic                   pc_index_valid,
    input  fetch_pkg::pc_t         pc_index,
    output logic                   pc_index_ready,
    output logic                   pc_operation_done,

    input  logic                   pc_redirect_valid,

    // memory read side
    output logic                   mem_rd_strobe,
    output logic [MEM_ADDR_W-1:0]  mem_rd_addr,
    input  logic                   mem_rd_valid,
    input  fetch_pkg::fetch_word_t mem_rd_data,

    // toward the instruction buffer
    output logic                   push_valid,
    output fetch_pkg::fetch_word_t push_data,
    output fetch_pkg::pc_t         push_pc
);

    logic           accept;
    logic           busy;       // read issued, reply not yet back
    logic           stale;      // pc moved on since this read was accepted
    logic           reply;
    logic           reply_good;
    fetch_pkg::pc_t req_pc;     // pc of the read in flight

    assign accept = pc_index_valid & pc_index_ready;
    assign reply  = mem_rd_valid & busy;

    // a reply in the redirect cycle is old too
    assign reply_good = reply & ~stale & ~pc_redirect_valid;

    assign pc_index_ready = ~busy;   // low from transfer until reply

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy          <= 1'b0;
            stale         <= 1'b0;
            mem_rd_strobe <= 1'b0;
        end else begin
            mem_rd_strobe <= accept;   // strobe one cycle after the transfer
            if (accept) begin
                busy  <= 1'b1;
                stale <= pc_redirect_valid;   // redirect in the accept cycle
            end else if (reply) begin
                busy  <= 1'b0;
                stale <= 1'b0;
            end else if (busy && pc_redirect_valid) begin
                stale <= 1'b1;
            end
        end
    end

    // payload, held for the life of the read
    always_ff @(posedge clock) begin
        if (accept) begin
            req_pc <= pc_index;
        end
    end

    assign mem_rd_addr = req_pc[fetch_pkg::WORD_LSB +: MEM_ADDR_W];   // pc[21:3]

    // done and push in the reply cycle
    assign pc_operation_done = reply_good;
    assign push_valid        = reply_good;
    assign push_data         = mem_rd_data;
    assign push_pc           = req_pc;

endmodule

`default_nettype wire

// ==== hdl/fetch_cfg_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_cfg_regs (
    input  logic                 clock,
    input  logic                 reset_n,

    // register bus
    input  logic                 cfg_write,
    input  fetch_pkg::cfg_addr_t cfg_addr,
    input  fetch_pkg::cfg_data_t cfg_wdata,
    output fetch_pkg::cfg_data_t cfg_rdata,

    // branch unit redirect
    input  logic                 redirect_valid,
    input  fetch_pkg::pc_t       redirect_target,

    input  logic                 pc_operation_done,   // one per delivered word

    output fetch_pkg::pc_t       boot_addr,
    output logic                 fetch_enable,
    output logic                 pc_redirect_valid,
    output fetch_pkg::pc_t       pc_redirect_target
);

    logic                 wr_ctrl;
    logic                 wr_boot_lo;
    logic                 wr_boot_hi;
    logic                 restart;
    fetch_pkg::cfg_data_t word_count;

    // write decode
    assign wr_ctrl    = cfg_write && (cfg_addr == fetch_pkg::CFG_CTRL);
    assign wr_boot_lo = cfg_write && (cfg_addr == fetch_pkg::CFG_BOOT_LO);
    assign wr_boot_hi = cfg_write && (cfg_addr == fetch_pkg::CFG_BOOT_HI);
    assign restart    = wr_ctrl && cfg_wdata[fetch_pkg::CTRL_RESTART_BIT];   // pulse only

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            fetch_enable <= fetch_pkg::FETCH_ENABLE_RESET;
            boot_addr    <= fetch_pkg::BOOT_ADDR_RESET;
        end else begin
            if (wr_ctrl) begin
                fetch_enable <= cfg_wdata[fetch_pkg::CTRL_ENABLE_BIT];
            end
            if (wr_boot_lo) begin
                boot_addr[31:0] <= cfg_wdata;
            end
            if (wr_boot_hi) begin
                boot_addr[63:32] <= cfg_wdata;
            end
        end
    end

    // delivered word count, restart starts a fresh count
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            word_count <= '0;
        end else if (restart) begin
            word_count <= '0;
        end else if (pc_operation_done) begin
            word_count <= word_count + 32'd1;
        end
    end

    // branch wins, restart goes back to boot
    assign pc_redirect_valid  = redirect_valid | restart;
    assign pc_redirect_target = redirect_valid ? redirect_target : boot_addr;

    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            fetch_pkg::CFG_CTRL:    cfg_rdata[fetch_pkg::CTRL_ENABLE_BIT] = fetch_enable;
            fetch_pkg::CFG_BOOT_LO: cfg_rdata = boot_addr[31:0];
            fetch_pkg::CFG_BOOT_HI: cfg_rdata = boot_addr[63:32];
            fetch_pkg::CFG_COUNT:   cfg_rdata = word_count;
            default:                cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/pc_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module pc_ctrl (
    input  logic           clock,
    input  logic           reset_n,

    input  fetch_pkg::pc_t boot_addr,          // value loaded while in reset
    input  logic           fetch_enable,

    // merged redirect from the config block
    input  logic           pc_redirect_valid,
    input  fetch_pkg::pc_t pc_redirect_target,

    input  logic           fetch_inst,         // buffer space level
    output fetch_pkg::pc_t pc,

    // index handshake toward the memory port
    output logic           pc_index_valid,
    output fetch_pkg::pc_t pc_index,
    input  logic           pc_index_ready,
    input  logic           pc_operation_done
);

    logic           pc_req_handshake;
    logic           pc_req_outstanding;
    logic           fetch_allowed;
    fetch_pkg::pc_t pc_next_seq;

    assign pc_req_handshake = pc_index_valid & pc_index_ready;
    assign fetch_allowed    = fetch_enable & fetch_inst;

    // drop the byte offset, then step one word
    assign pc_next_seq = (pc & ~(fetch_pkg::FETCH_BYTES - 64'd1)) + fetch_pkg::FETCH_BYTES;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pc <= boot_addr;
        end else if (pc_redirect_valid) begin
            pc <= pc_redirect_target;       // redirect beats a done in the same cycle
        end else if (pc_operation_done) begin
            pc <= pc_next_seq;
        end
    end

    // one read at a time
    // redirect also clears it, the stale reply never reports done
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pc_req_outstanding <= 1'b0;
        end else if (pc_redirect_valid) begin
            pc_req_outstanding <= 1'b0;
        end else if (pc_req_handshake) begin
            pc_req_outstanding <= 1'b1;
        end else if (pc_operation_done) begin
            pc_req_outstanding <= 1'b0;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pc_index_valid <= 1'b0;
        end else if (pc_redirect_valid) begin
            pc_index_valid <= fetch_enable;   // buffer flushes too, so space is there
        end else if (fetch_allowed && !pc_req_outstanding && !pc_req_handshake) begin
            pc_index_valid <= 1'b1;
        end else begin
            pc_index_valid <= 1'b0;          // low the cycle after a transfer
        end
    end

    assign pc_index = pc;   // full pc, memory port picks the index bits

endmodule

`default_nettype wire

// ==== hdl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // widths
    localparam int unsigned PC_W       = 64;
    localparam int unsigned WORD_W     = 64;
    localparam int unsigned MEM_ADDR_W = 19;   // pc[21:3] by default
    localparam int unsigned WORD_LSB   = 3;    // byte offset bits inside a fetch word
    localparam int unsigned CFG_ADDR_W = 2;
    localparam int unsigned CFG_DATA_W = 32;

    typedef logic [PC_W-1:0]       pc_t;          // byte address
    typedef logic [MEM_ADDR_W-1:0] word_addr_t;   // memory word index
    typedef logic [WORD_W-1:0]     fetch_word_t;  // one 8-byte fetch word
    typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;
    typedef logic [CFG_DATA_W-1:0] cfg_data_t;

    // register map
    localparam cfg_addr_t CFG_CTRL    = 2'd0;
    localparam cfg_addr_t CFG_BOOT_LO = 2'd1;
    localparam cfg_addr_t CFG_BOOT_HI = 2'd2;
    localparam cfg_addr_t CFG_COUNT   = 2'd3;   // read only

    // CTRL fields
    localparam int unsigned CTRL_ENABLE_BIT  = 0;
    localparam int unsigned CTRL_RESTART_BIT = 1;   // write pulse, reads 0

    // reset values
    localparam pc_t  BOOT_ADDR_RESET    = 64'h0000_0000_0000_1000;
    localparam logic FETCH_ENABLE_RESET = 1'b1;

    // pc step between fetch words
    localparam pc_t FETCH_BYTES = 64'd8;

endpackage

`default_nettype wire
